/* gb_pulse_apu.f */
+incdir+src
src/apu_pkg.sv
src/pulse_cfg_if.sv
src/frame_sequencer.sv
src/apu_regs.sv
src/pulse_channel.sv
src/apu_mixer.sv
src/gb_pulse_apu.sv
tb/gb_pulse_apu_assert.sv
tb/gb_pulse_apu_tb.sv

/* src/apu_mixer.sv */
`timescale 1ns/1ps

module apu_mixer import apu_pkg::*; (
  input  sample_t     sample1,
  input  sample_t     sample2,
  input  logic        running1,
  input  logic        running2,
  input  logic [1:0]  mix_l,
  input  logic [1:0]  mix_r,
  input  master_vol_t vol_l,
  input  master_vol_t vol_r,
  output apu_out_t    out_l,
  output apu_out_t    out_r
);

  // one side: routed running channels summed, then scaled
  function automatic apu_out_t mix_side(
    input logic [1:0]  route,
    input master_vol_t vol,
    input sample_t     s1,
    input sample_t     s2,
    input logic        run1,
    input logic        run2
  );
    logic [4:0] sum;
    sum = '0;
    if (route[0] && run1) begin
      sum = sum + {1'b0, s1};
    end
    if (route[1] && run2) begin
      sum = sum + {1'b0, s2};
    end
    // 30 * 8 at most, fits the 9-bit side
    return apu_out_t'(sum) * apu_out_t'(vol);
  endfunction

  // ----------------------------------------
  // left and right
  // ----------------------------------------

  assign out_l = mix_side(mix_l, vol_l, sample1, sample2, running1, running2);
  assign out_r = mix_side(mix_r, vol_r, sample1, sample2, running1, running2);

endmodule

/* src/apu_pkg.sv */
`include "gb_pulse_apu_cfg.svh"

package apu_pkg;

  // ----------------------------------------
  // channel register fields
  // ----------------------------------------

  // duty select, 12.5 / 25 / 50 / 75 percent
  typedef logic [1:0] duty_t;
  // envelope level or initial level
  typedef logic [3:0] vol_t;
  // envelope step period in env ticks
  typedef logic [2:0] env_period_t;
  // frequency reload value
  typedef logic [`APU_FREQ_W-1:0] freq_t;
  // length initial value
  typedef logic [`APU_LEN_W-1:0] len_t;

  // ----------------------------------------
  // mixer values
  // ----------------------------------------

  // written 3-bit field plus one, so 1..8
  typedef logic [3:0] master_vol_t;
  // one channel output level
  typedef logic [3:0] sample_t;
  // one side after summing and scaling
  typedef logic [`APU_OUT_W-1:0] apu_out_t;

endpackage

/* src/apu_regs.sv */
`timescale 1ns/1ps
`include "gb_pulse_apu_cfg.svh"

module apu_regs import apu_pkg::*; (
  input  logic         clock,
  input  logic         tick_reset,
  input  logic [15:0]  tick_addr,
  input  logic [7:0]   tick_data_in,
  input  logic         tick_write,
  pulse_cfg_if.regs    ch1,
  pulse_cfg_if.regs    ch2,
  output logic [1:0]   mix_l,
  output logic [1:0]   mix_r,
  output master_vol_t  vol_l,
  output master_vol_t  vol_r
);

  // start only with a nonzero level or a rising envelope
  function automatic logic trig_ok(input logic bit7, input vol_t vol_init, input logic add);
    return bit7 && ((vol_init != '0) || add);
  endfunction

  // ----------------------------------------
  // write decode
  // ----------------------------------------

  always_ff @(posedge clock) begin
    if (tick_reset) begin
      ch1.duty         <= '0;
      ch1.len_init     <= '0;
      ch1.env_vol_init <= '0;
      ch1.env_add      <= 1'b0;
      ch1.env_period   <= '0;
      ch1.freq_init    <= '0;
      ch1.len_en       <= 1'b0;
      ch1.trig         <= 1'b0;
      ch2.duty         <= '0;
      ch2.len_init     <= '0;
      ch2.env_vol_init <= '0;
      ch2.env_add      <= 1'b0;
      ch2.env_period   <= '0;
      ch2.freq_init    <= '0;
      ch2.len_en       <= 1'b0;
      ch2.trig         <= 1'b0;
      mix_l            <= '0;
      mix_r            <= '0;
      vol_l            <= '0;
      vol_r            <= '0;
    end else begin
      // trig pulses drop after one cycle
      ch1.trig <= 1'b0;
      ch2.trig <= 1'b0;
      if (tick_write) begin
        case (tick_addr)
          // channel 1
          `APU_ADDR_NR11: begin
            ch1.duty     <= tick_data_in[7:6];
            ch1.len_init <= tick_data_in[5:0];
          end
          `APU_ADDR_NR12: begin
            ch1.env_vol_init <= tick_data_in[7:4];
            ch1.env_add      <= tick_data_in[3];
            ch1.env_period   <= tick_data_in[2:0];
          end
          `APU_ADDR_NR13: ch1.freq_init <= {ch1.freq_init[10:8], tick_data_in};
          `APU_ADDR_NR14: begin
            ch1.freq_init <= {tick_data_in[2:0], ch1.freq_init[7:0]};
            ch1.len_en    <= tick_data_in[6];
            // NR12 is untouched by this write, so its stored value is current
            ch1.trig      <= trig_ok(tick_data_in[7], ch1.env_vol_init, ch1.env_add);
          end
          // channel 2
          `APU_ADDR_NR21: begin
            ch2.duty     <= tick_data_in[7:6];
            ch2.len_init <= tick_data_in[5:0];
          end
          `APU_ADDR_NR22: begin
            ch2.env_vol_init <= tick_data_in[7:4];
            ch2.env_add      <= tick_data_in[3];
            ch2.env_period   <= tick_data_in[2:0];
          end
          `APU_ADDR_NR23: ch2.freq_init <= {ch2.freq_init[10:8], tick_data_in};
          `APU_ADDR_NR24: begin
            ch2.freq_init <= {tick_data_in[2:0], ch2.freq_init[7:0]};
            ch2.len_en    <= tick_data_in[6];
            ch2.trig      <= trig_ok(tick_data_in[7], ch2.env_vol_init, ch2.env_add);
          end
          // master volume, stored plus one
          `APU_ADDR_NR50: begin
            vol_l <= {1'b0, tick_data_in[6:4]} + 4'd1;
            vol_r <= {1'b0, tick_data_in[2:0]} + 4'd1;
          end
          // routing, bit 0 ch1 and bit 1 ch2 per side
          `APU_ADDR_NR51: begin
            mix_l <= tick_data_in[5:4];
            mix_r <= tick_data_in[1:0];
          end
          default: begin
            // other addresses ignored
          end
        endcase
      end
    end
  end

endmodule

/* src/frame_sequencer.sv */
`timescale 1ns/1ps
`include "gb_pulse_apu_cfg.svh"

module frame_sequencer (
  input  logic clock,
  input  logic tick_reset,
  output logic len_tick,
  output logic env_tick
);

  logic [`APU_FRAME_W-1:0] frame_cnt;
  logic [`APU_FRAME_W-1:0] frame_next;
  logic [`APU_FRAME_W-1:0] frame_rise;

  // bits going 0 -> 1 on this increment
  assign frame_next = frame_cnt + 1'b1;
  assign frame_rise = ~frame_cnt & frame_next;

  // ----------------------------------------
  // free-running counter and tick pulses
  // ----------------------------------------

  always_ff @(posedge clock) begin
    if (tick_reset) begin
      frame_cnt <= '0;
      len_tick  <= 1'b0;
      env_tick  <= 1'b0;
    end else begin
      frame_cnt <= frame_next;
      // every 4096 cycles
      len_tick  <= frame_rise[`APU_LEN_TICK_BIT];
      // every 16384 cycles
      env_tick  <= frame_rise[`APU_ENV_TICK_BIT];
    end
  end

endmodule

/* src/gb_pulse_apu.sv */
`timescale 1ns/1ps

module gb_pulse_apu import apu_pkg::*; (
  input  logic        clock,
  input  logic        tick_reset,
  input  logic [15:0] tick_addr,
  input  logic [7:0]  tick_data_in,
  input  logic        tick_write,
  output apu_out_t    out_l,
  output apu_out_t    out_r
);

  // per-channel register settings
  pulse_cfg_if ch1_cfg ();
  pulse_cfg_if ch2_cfg ();

  logic        len_tick;
  logic        env_tick;
  sample_t     sample1;
  sample_t     sample2;
  logic        running1;
  logic        running2;
  logic [1:0]  mix_l;
  logic [1:0]  mix_r;
  master_vol_t vol_l;
  master_vol_t vol_r;

  // ----------------------------------------
  // host writes
  // ----------------------------------------

  apu_regs u_regs (
    .clock        (clock),
    .tick_reset   (tick_reset),
    .tick_addr    (tick_addr),
    .tick_data_in (tick_data_in),
    .tick_write   (tick_write),
    .ch1          (ch1_cfg.regs),
    .ch2          (ch2_cfg.regs),
    .mix_l        (mix_l),
    .mix_r        (mix_r),
    .vol_l        (vol_l),
    .vol_r        (vol_r)
  );

  // shared length and envelope ticks
  frame_sequencer u_frame (
    .clock      (clock),
    .tick_reset (tick_reset),
    .len_tick   (len_tick),
    .env_tick   (env_tick)
  );

  // ----------------------------------------
  // channels and mixer
  // ----------------------------------------

  pulse_channel u_ch1 (
    .clock      (clock),
    .tick_reset (tick_reset),
    .cfg        (ch1_cfg.chan),
    .len_tick   (len_tick),
    .env_tick   (env_tick),
    .sample     (sample1),
    .running    (running1)
  );

  pulse_channel u_ch2 (
    .clock      (clock),
    .tick_reset (tick_reset),
    .cfg        (ch2_cfg.chan),
    .len_tick   (len_tick),
    .env_tick   (env_tick),
    .sample     (sample2),
    .running    (running2)
  );

  apu_mixer u_mixer (
    .sample1  (sample1),
    .sample2  (sample2),
    .running1 (running1),
    .running2 (running2),
    .mix_l    (mix_l),
    .mix_r    (mix_r),
    .vol_l    (vol_l),
    .vol_r    (vol_r),
    .out_l    (out_l),
    .out_r    (out_r)
  );

endmodule

/* src/gb_pulse_apu_cfg.svh */
`ifndef GB_PULSE_APU_CFG_SVH
`define GB_PULSE_APU_CFG_SVH

// register map, channel 1 then channel 2
`define APU_ADDR_NR11 16'hFF11
`define APU_ADDR_NR12 16'hFF12
`define APU_ADDR_NR13 16'hFF13
`define APU_ADDR_NR14 16'hFF14
`define APU_ADDR_NR21 16'hFF16
`define APU_ADDR_NR22 16'hFF17
`define APU_ADDR_NR23 16'hFF18
`define APU_ADDR_NR24 16'hFF19
// master volume and routing
`define APU_ADDR_NR50 16'hFF24
`define APU_ADDR_NR51 16'hFF25

// channel widths and wrap points
`define APU_FREQ_W    11
`define APU_FREQ_WRAP 2047
`define APU_LEN_W     6
`define APU_LEN_WRAP  63
`define APU_ENV_MAX   15

// frame counter taps
`define APU_FRAME_W      16
`define APU_LEN_TICK_BIT 11
`define APU_ENV_TICK_BIT 13

`define APU_OUT_W 9

`endif

/* src/pulse_cfg_if.sv */
`timescale 1ns/1ps

interface pulse_cfg_if import apu_pkg::*; ();

  // NRx1
  duty_t       duty;
  len_t        len_init;
  // NRx2
  vol_t        env_vol_init;
  logic        env_add;
  env_period_t env_period;
  // NRx3 low byte, NRx4 high bits
  freq_t       freq_init;
  logic        len_en;
  // qualified one-cycle start pulse
  logic        trig;

  // register block side
  modport regs (output duty, len_init, env_vol_init, env_add, env_period,
                output freq_init, len_en, trig);
  // channel side
  modport chan (input duty, len_init, env_vol_init, env_add, env_period,
                input freq_init, len_en, trig);

endinterface

/* src/pulse_channel.sv */
`timescale 1ns/1ps
`include "gb_pulse_apu_cfg.svh"

module pulse_channel import apu_pkg::*; (
  input  logic        clock,
  input  logic        tick_reset,
  pulse_cfg_if.chan   cfg,
  input  logic        len_tick,
  input  logic        env_tick,
  output sample_t     sample,
  output logic        running
);

  freq_t       freq_timer;
  logic [2:0]  phase;
  len_t        len_timer;
  vol_t        env_vol;
  env_period_t env_timer;
  logic        duty_high;

  // ----------------------------------------
  // duty waveform
  // ----------------------------------------

  always_comb begin
    case (cfg.duty)
      2'd0:    duty_high = (phase < 3'd1);
      2'd1:    duty_high = (phase < 3'd2);
      2'd2:    duty_high = (phase < 3'd4);
      default: duty_high = (phase < 3'd6);
    endcase
  end

  // level only while high and running
  assign sample = (running && duty_high) ? env_vol : '0;

  // ----------------------------------------
  // timers
  // ----------------------------------------

  always_ff @(posedge clock) begin
    if (tick_reset) begin
      running    <= 1'b0;
      freq_timer <= '0;
      phase      <= '0;
      len_timer  <= '0;
      env_vol    <= '0;
      env_timer  <= '0;
    end else if (cfg.trig) begin
      // restart, trigger already qualified upstream
      running    <= 1'b1;
      freq_timer <= cfg.freq_init;
      phase      <= '0;
      len_timer  <= cfg.len_init;
      env_vol    <= cfg.env_vol_init;
      env_timer  <= cfg.env_period;
    end else begin
      // frequency timer
      // counts up from freq_init, so 2048 - freq_init cycles per step
      if (freq_timer == freq_t'(`APU_FREQ_WRAP)) begin
        freq_timer <= cfg.freq_init;
        phase      <= phase + 3'd1;
      end else begin
        freq_timer <= freq_timer + freq_t'(1);
      end

      // length counter
      // 64 - len_init ticks until the channel stops
      if (len_tick && running && cfg.len_en) begin
        if (len_timer == len_t'(`APU_LEN_WRAP)) begin
          len_timer <= '0;
          running   <= 1'b0;
        end else begin
          len_timer <= len_timer + len_t'(1);
        end
      end

      // envelope
      // period 0 holds the level
      if (env_tick && (cfg.env_period != '0)) begin
        if (env_timer > env_period_t'(1)) begin
          env_timer <= env_timer - env_period_t'(1);
        end else begin
          // one step per env_period ticks
          env_timer <= cfg.env_period;
          if (cfg.env_add) begin
            if (env_vol < vol_t'(`APU_ENV_MAX)) begin
              env_vol <= env_vol + vol_t'(1);
            end
          end else if (env_vol != '0) begin
            env_vol <= env_vol - vol_t'(1);
          end
        end
      end
    end
  end

endmodule

/* tb/gb_pulse_apu_assert.sv */
`timescale 1ns/1ps

module gb_pulse_apu_assert import apu_pkg::*; (
  input logic    clock,
  input logic    tick_reset,
  input logic    pulse_a,
  input logic    pulse_b,
  input sample_t sample,
  input logic    running
);

  // failure tally
  int fail_count;

  // ----------------------------------------
  // one-cycle strobes
  // ----------------------------------------

  pulse_a_single: assert property (
    @(posedge clock) disable iff (tick_reset) pulse_a |=> !pulse_a
  ) else begin
    fail_count++;
    $error("first strobe stayed high for two cycles");
  end

  pulse_b_single: assert property (
    @(posedge clock) disable iff (tick_reset) pulse_b |=> !pulse_b
  ) else begin
    fail_count++;
    $error("second strobe stayed high for two cycles");
  end

  // stopped channel is silent
  silent_when_stopped: assert property (
    @(posedge clock) disable iff (tick_reset) !running |-> (sample == '0)
  ) else begin
    fail_count++;
    $error("channel sample nonzero while not running");
  end

endmodule

// trig pulses of both channels, no sample in the register block
bind apu_regs gb_pulse_apu_assert u_assert (
  .clock      (clock),
  .tick_reset (tick_reset),
  .pulse_a    (ch1.trig),
  .pulse_b    (ch2.trig),
  .sample     ('0),
  .running    (1'b1)
);

// frame ticks and sample gating, per channel
bind pulse_channel gb_pulse_apu_assert u_assert (
  .clock      (clock),
  .tick_reset (tick_reset),
  .pulse_a    (len_tick),
  .pulse_b    (env_tick),
  .sample     (sample),
  .running    (running)
);

/* tb/gb_pulse_apu_tb.sv */
`timescale 1ns/1ps
`include "gb_pulse_apu_cfg.svh"

module gb_pulse_apu_tb import apu_pkg::*; ();

  localparam int    CLK_PERIOD   = 8;
  localparam int    RESET_CYCLES = 8;
  localparam int    MIX_ROUNDS   = 3;
  // 8 cycles per phase, 64 per duty period
  localparam freq_t DUTY_FREQ    = 11'd2040;

  // cycle budgets per test
  localparam int DUTY_BUDGET  = 4 * 400;
  localparam int MIX_BUDGET   = MIX_ROUNDS * 300;
  localparam int TRIG_BUDGET  = 700;
  localparam int LEN_BUDGET   = 6 * 4096 + 1300;
  localparam int ENV_BUDGET   = 3 * 16384 + 400;
  localparam int WATCHDOG_CYCLES = 300 + DUTY_BUDGET + MIX_BUDGET + TRIG_BUDGET
                                 + LEN_BUDGET + ENV_BUDGET + 4096;

  logic        clock;
  logic        tick_reset;
  logic [15:0] tick_addr;
  logic [7:0]  tick_data_in;
  logic        tick_write;
  apu_out_t    out_l;
  apu_out_t    out_r;

  integer seed;
  string  test_name;
  int     errors;
  int     cycle_cnt;
  // side must stay silent while set
  logic   zero_l_en;
  logic   zero_r_en;

  gb_pulse_apu UUT (
    .clock        (clock),
    .tick_reset   (tick_reset),
    .tick_addr    (tick_addr),
    .tick_data_in (tick_data_in),
    .tick_write   (tick_write),
    .out_l        (out_l),
    .out_r        (out_r)
  );

  // ----------------------------------------
  // clock, watchdog, frame count model
  // ----------------------------------------

  initial begin
    clock = 1'b0;
    forever #(CLK_PERIOD / 2) clock = ~clock;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog expired before the tests finished");
    $display("SOME TESTS FAILED");
    $fatal(1, "run stopped by the watchdog");
  end

  // mirrors the free-running frame counter, 0 on the last reset edge
  always @(posedge clock) begin
    if (tick_reset) begin
      cycle_cnt <= 0;
    end else begin
      cycle_cnt <= cycle_cnt + 1;
    end
  end

  // ----------------------------------------
  // reference and compare
  // ----------------------------------------

  // expected side level from NR50, NR51, channel volumes and duty states
  function automatic apu_out_t expected_level(
    input logic       right_side,
    input logic [7:0] nr50,
    input logic [7:0] nr51,
    input vol_t       vol1,
    input vol_t       vol2,
    input logic       high1,
    input logic       high2
  );
    logic [1:0] route;
    int         master;
    int         sum;
    route  = right_side ? nr51[1:0] : nr51[5:4];
    master = (right_side ? nr50[2:0] : nr50[6:4]) + 1;
    sum    = 0;
    if (route[0] && high1) begin
      sum += vol1;
    end
    if (route[1] && high2) begin
      sum += vol2;
    end
    return apu_out_t'(sum * master);
  endfunction

  // phases out of 8 with the duty output high
  function automatic int duty_high_phases(input int duty);
    case (duty)
      0:       return 1;
      1:       return 2;
      2:       return 4;
      default: return 6;
    endcase
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      errors++;
      $display("[FAIL] %s: expected %0d, actual %0d", name, expected, actual);
      $display("SOME TESTS FAILED");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  // silence checks on every falling edge
  always @(negedge clock) begin
    if (zero_l_en) begin
      check_value({test_name, " left silent"}, 32'd0, out_l);
    end
    if (zero_r_en) begin
      check_value({test_name, " right silent"}, 32'd0, out_r);
    end
  end

  // ----------------------------------------
  // bus and measurement tasks
  // ----------------------------------------

  task automatic apply_reset();
    @(posedge clock);
    #1;
    tick_reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clock);
    #1;
    tick_reset = 1'b0;
  endtask

  // one-cycle write strobe
  task automatic write_reg(input logic [15:0] addr, input logic [7:0] data);
    @(posedge clock);
    #1;
    tick_addr    = addr;
    tick_data_in = data;
    tick_write   = 1'b1;
    @(posedge clock);
    #1;
    tick_write = 1'b0;
  endtask

  // NRx1..NRx4, last write carries the trigger bit
  task automatic trigger_channel(input int ch, input duty_t duty, input len_t len_init,
                                 input vol_t vol, input logic add, input env_period_t period,
                                 input freq_t freq, input logic len_en);
    logic [15:0] addr1;
    logic [15:0] addr2;
    logic [15:0] addr3;
    logic [15:0] addr4;
    addr1 = (ch == 1) ? `APU_ADDR_NR11 : `APU_ADDR_NR21;
    addr2 = (ch == 1) ? `APU_ADDR_NR12 : `APU_ADDR_NR22;
    addr3 = (ch == 1) ? `APU_ADDR_NR13 : `APU_ADDR_NR23;
    addr4 = (ch == 1) ? `APU_ADDR_NR14 : `APU_ADDR_NR24;
    write_reg(addr1, {duty, len_init});
    write_reg(addr2, {vol, add, period});
    write_reg(addr3, freq[7:0]);
    write_reg(addr4, {1'b1, len_en, 3'b000, freq[10:8]});
  endtask

  // peaks of both sides and high count of the left side
  task automatic measure_window(input int cycles, output apu_out_t peak_l,
                                output apu_out_t peak_r, output int high_l);
    peak_l = '0;
    peak_r = '0;
    high_l = 0;
    repeat (cycles) begin
      @(negedge clock);
      if (out_l > peak_l) begin
        peak_l = out_l;
      end
      if (out_r > peak_r) begin
        peak_r = out_r;
      end
      if (out_l != '0) begin
        high_l++;
      end
    end
  endtask

  task automatic wait_until_cycle(input int target);
    while (cycle_cnt < target) begin
      @(posedge clock);
      #1;
    end
  endtask

  // ----------------------------------------
  // tests
  // ----------------------------------------

  initial begin
    apu_out_t   peak_l;
    apu_out_t   peak_r;
    int         high_l;
    int         assert_fails;
    int         t_start;
    logic [31:0] rnd;
    logic [7:0] nr50;
    logic [7:0] nr51;
    vol_t       v1;
    vol_t       v2;
    seed         = 32'h5220a2f5;
    errors       = 0;
    tick_reset   = 1'b1;
    tick_addr    = '0;
    tick_data_in = '0;
    tick_write   = 1'b0;

    // reset, outputs silent during and after
    test_name = "reset";
    zero_l_en = 1'b0;
    zero_r_en = 1'b0;
    // registers hold X until the first reset edge
    @(posedge clock);
    #1;
    zero_l_en = 1'b1;
    zero_r_en = 1'b1;
    repeat (RESET_CYCLES - 1) @(posedge clock);
    #1;
    tick_reset = 1'b0;
    repeat (16) @(posedge clock);
    zero_l_en = 1'b0;
    zero_r_en = 1'b0;

    // duty, high cycles over four periods
    test_name = "duty";
    apply_reset();
    write_reg(`APU_ADDR_NR50, 8'h00);
    write_reg(`APU_ADDR_NR51, 8'h11);
    for (int d = 0; d < 4; d++) begin
      trigger_channel(1, d[1:0], '0, 4'd15, 1'b0, '0, DUTY_FREQ, 1'b0);
      repeat (2) @(posedge clock);
      measure_window(256, peak_l, peak_r, high_l);
      check_value($sformatf("duty %0d high cycles", d),
                  duty_high_phases(d) * (2048 - DUTY_FREQ) * 4, high_l);
    end

    // random volumes and routing, duty 3, envelope held
    test_name = "mixing";
    apply_reset();
    for (int r = 0; r < MIX_ROUNDS; r++) begin
      zero_l_en = 1'b0;
      zero_r_en = 1'b0;
      rnd  = $random(seed);
      nr50 = rnd[7:0];
      nr51 = rnd[15:8];
      v1   = vol_t'(1 + rnd[19:16] % 15);
      v2   = vol_t'(1 + rnd[23:20] % 15);
      write_reg(`APU_ADDR_NR50, nr50);
      write_reg(`APU_ADDR_NR51, nr51);
      trigger_channel(1, 2'd3, '0, v1, 1'b0, '0, DUTY_FREQ, 1'b0);
      trigger_channel(2, 2'd3, '0, v2, 1'b0, '0, DUTY_FREQ, 1'b0);
      zero_l_en = (nr51[5:4] == 2'b00);
      zero_r_en = (nr51[1:0] == 2'b00);
      repeat (2) @(posedge clock);
      measure_window(128, peak_l, peak_r, high_l);
      check_value($sformatf("mixing round %0d left peak", r),
                  expected_level(1'b0, nr50, nr51, v1, v2, 1'b1, 1'b1), peak_l);
      check_value($sformatf("mixing round %0d right peak", r),
                  expected_level(1'b1, nr50, nr51, v1, v2, 1'b1, 1'b1), peak_r);
    end
    zero_l_en = 1'b0;
    zero_r_en = 1'b0;

    // zero volume without envelope add does not start
    test_name = "trigger rule";
    apply_reset();
    nr50 = 8'h77;
    nr51 = 8'h11;
    write_reg(`APU_ADDR_NR50, nr50);
    write_reg(`APU_ADDR_NR51, nr51);
    zero_l_en = 1'b1;
    zero_r_en = 1'b1;
    trigger_channel(1, 2'd2, '0, 4'd0, 1'b0, '0, DUTY_FREQ, 1'b0);
    repeat (256) @(posedge clock);
    // a silent start would look the same at the outputs
    check_value("trigger rule channel stopped", 32'd0, UUT.running1);
    zero_l_en = 1'b0;
    zero_r_en = 1'b0;
    // same channel with a real volume does sound
    trigger_channel(1, 2'd2, '0, 4'd8, 1'b0, '0, DUTY_FREQ, 1'b0);
    repeat (2) @(posedge clock);
    measure_window(128, peak_l, peak_r, high_l);
    check_value("trigger rule control peak",
                expected_level(1'b0, nr50, nr51, 4'd8, 4'd0, 1'b1, 1'b0), peak_l);

    // length 60, four ticks to stop
    test_name = "length";
    apply_reset();
    nr50 = 8'h00;
    nr51 = 8'h11;
    write_reg(`APU_ADDR_NR50, nr50);
    write_reg(`APU_ADDR_NR51, nr51);
    trigger_channel(1, 2'd2, 6'd60, 4'd15, 1'b0, '0, DUTY_FREQ, 1'b1);
    t_start = cycle_cnt;
    wait_until_cycle(t_start + 2 * 4096);
    measure_window(128, peak_l, peak_r, high_l);
    check_value("length still sounding",
                expected_level(1'b0, nr50, nr51, 4'd15, 4'd0, 1'b1, 1'b0), peak_l);
    wait_until_cycle(t_start + 6 * 4096);
    zero_l_en = 1'b1;
    zero_r_en = 1'b1;
    repeat (1024) @(posedge clock);
    zero_l_en = 1'b0;
    zero_r_en = 1'b0;

    // envelope down from 15, period 1
    // ticks near 8192 + 16384k, checks at the midpoints
    test_name = "envelope";
    apply_reset();
    nr50 = 8'h33;
    nr51 = 8'h11;
    write_reg(`APU_ADDR_NR50, nr50);
    write_reg(`APU_ADDR_NR51, nr51);
    trigger_channel(1, 2'd2, '0, 4'd15, 1'b0, 3'd1, DUTY_FREQ, 1'b0);
    for (int k = 0; k < 4; k++) begin
      wait_until_cycle((k == 0) ? 4096 : 16384 * k);
      measure_window(128, peak_l, peak_r, high_l);
      check_value($sformatf("envelope after %0d ticks", k),
                  expected_level(1'b0, nr50, nr51, vol_t'(15 - k), 4'd0, 1'b1, 1'b0),
                  peak_l);
    end

    // bound checker tallies
    assert_fails = UUT.u_regs.u_assert.fail_count + UUT.u_ch1.u_assert.fail_count
                 + UUT.u_ch2.u_assert.fail_count;
    if (assert_fails != 0) begin
      $display("%0d bound assertions failed during the run", assert_fails);
      errors++;
    end

    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule
